//--- design/ccu_consts.svh
`ifndef CCU_CONSTS_SVH
`define CCU_CONSTS_SVH

// Instruction RAM geometry
`define CCU_ADDR_W      16
`define CCU_ISA_W       128
`define CCU_OPCODE_W    8       // Low bits of every word

// Network control
`define CCU_LAYER_W     20
`define CCU_NUM_TGT     3       // CCU, SYA, POL

// Block lengths in words, per target
`define CCU_WORDS_CCU   1
`define CCU_WORDS_SYA   2
`define CCU_WORDS_POL   2

`endif

//--- design/ccu_isa_pkg.sv
`include "ccu_consts.svh"

package ccu_isa_pkg;

    // Opcode in the low byte, equal to the target index
    typedef enum logic [`CCU_OPCODE_W-1:0] {
        OP_CCU = 8'd0,
        OP_SYA = 8'd1,
        OP_POL = 8'd2
    } opcode_e;

    typedef logic [`CCU_ISA_W-1:0]   isa_word_t;
    typedef logic [`CCU_ADDR_W-1:0]  isa_addr_t;
    typedef logic [1:0]              word_idx_t;    // Matched word within a block
    typedef logic [`CCU_LAYER_W-1:0] layer_cnt_t;

    // Field vectors carried in the words
    typedef logic [1:0]  mode_t;
    typedef logic [15:0] idx_t;         // Point count
    typedef logic [11:0] chn_t;         // Input channels
    typedef logic [19:0] qnt_scale_t;   // Requant multiplier
    typedef logic [7:0]  act_t;         // Shift and zero point
    typedef logic [5:0]  knn_k_t;       // Neighbours per point

endpackage

//--- design/ccu_cfg_pkg.sv
package ccu_cfg_pkg;

    // Target index, also the opcode of its blocks
    typedef enum logic [1:0] {
        TGT_CCU = 2'd0,
        TGT_SYA = 2'd1,
        TGT_POL = 2'd2
    } tgt_e;

    // Systolic array layer config
    typedef struct packed {
        ccu_isa_pkg::mode_t      mode;
        ccu_isa_pkg::idx_t       nip;
        ccu_isa_pkg::chn_t       chi;
        ccu_isa_pkg::qnt_scale_t scale;
        ccu_isa_pkg::act_t       shift;
        ccu_isa_pkg::act_t       zp;
        ccu_isa_pkg::isa_addr_t  act_base;     // Activation read base
        ccu_isa_pkg::isa_addr_t  wgt_base;     // Weight read base
        ccu_isa_pkg::isa_addr_t  ofm_base;     // Output map write base
    } sya_cfg_t;

    // Pooling core config
    typedef struct packed {
        ccu_isa_pkg::knn_k_t     k;
        ccu_isa_pkg::idx_t       nip;
        ccu_isa_pkg::chn_t       chi;
        ccu_isa_pkg::isa_addr_t  map_base;     // Neighbour map read base
    } pol_cfg_t;

endpackage

//--- design/ccu_sequencer.sv
`timescale 1ns/1ps

module ccu_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  logic                    sya_rdy_i,
    input  logic                    pol_rdy_i,
    input  logic                    cfg_taken_i,
    input  ccu_isa_pkg::layer_cnt_t num_layers_i,
    output logic                    fetch_go_o,
    output ccu_cfg_pkg::tgt_e       grant_o,
    output logic                    net_done_o,
    output logic                    sya_rst_o,
    output logic                    pol_rst_o,
    output logic                    idle_o
);

    import ccu_isa_pkg::*;
    import ccu_cfg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARB,
        ST_CFG,
        ST_DONE
    } state_e;

    state_e     state_q;
    state_e     state_d;
    logic       ccu_req_q;      // Own layer-count block still pending
    logic       any_req;
    tgt_e       arb_tgt;
    layer_cnt_t sya_cnt_q;
    layer_cnt_t sya_cnt_nxt;
    logic       sya_taken;
    logic       net_fnh;

    //==========================================================================
    // Fixed priority, CCU first, then SYA, then POL
    //==========================================================================
    always_comb begin
        if (ccu_req_q) begin
            arb_tgt = TGT_CCU;
        end else if (sya_rdy_i) begin
            arb_tgt = TGT_SYA;
        end else begin
            arb_tgt = TGT_POL;
        end
    end

    assign any_req = ccu_req_q | sya_rdy_i | pol_rdy_i;

    // Layer count is the number of SYA deliveries
    assign sya_taken   = cfg_taken_i & (grant_o == TGT_SYA);
    assign sya_cnt_nxt = sya_cnt_q + layer_cnt_t'(1);
    assign net_fnh     = sya_taken & (num_layers_i != '0) & (sya_cnt_nxt == num_layers_i);

    //==========================================================================
    // Top FSM
    //==========================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (start_i) state_d = ST_ARB;
            ST_ARB:  if (any_req) state_d = ST_CFG;
            ST_CFG: begin
                if (net_fnh) begin
                    state_d = ST_DONE;
                end else if (cfg_taken_i) begin
                    state_d = ST_ARB;
                end
            end
            ST_DONE: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Grant latched with a one-cycle go strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_o    <= TGT_CCU;
            fetch_go_o <= 1'b0;
        end else begin
            fetch_go_o <= (state_q == ST_ARB) & any_req;
            if ((state_q == ST_ARB) && any_req) begin
                grant_o <= arb_tgt;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ccu_req_q <= 1'b0;
            sya_cnt_q <= '0;
        end else if (state_q == ST_IDLE) begin
            ccu_req_q <= 1'b1;     // Re-armed for every network
            sya_cnt_q <= '0;
        end else begin
            if (cfg_taken_i && grant_o == TGT_CCU) begin
                ccu_req_q <= 1'b0;
            end
            if (sya_taken) begin
                sya_cnt_q <= sya_cnt_nxt;
            end
        end
    end

    assign net_done_o = (state_q == ST_DONE);
    assign idle_o     = (state_q == ST_IDLE);
    assign sya_rst_o  = idle_o;    // Targets held in reset between networks
    assign pol_rst_o  = idle_o;

endmodule

//--- design/isa_fetch.sv
`timescale 1ns/1ps
`include "ccu_consts.svh"

module isa_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   idle_i,
    input  logic                   fetch_go_i,
    input  ccu_cfg_pkg::tgt_e      grant_i,
    output ccu_isa_pkg::isa_addr_t glb_addr_o,
    output logic                   glb_addr_vld_o,
    input  logic                   glb_addr_rdy_i,
    input  ccu_isa_pkg::isa_word_t glb_dat_i,
    input  logic                   glb_dat_vld_i,
    output logic                   glb_dat_rdy_o,
    output ccu_isa_pkg::isa_word_t word_o,
    output logic                   word_stb_o,
    output ccu_isa_pkg::word_idx_t word_idx_o,
    output logic                   word_last_o
);

    import ccu_isa_pkg::*;

    typedef enum logic [1:0] {
        PH_OFF,
        PH_ADDR,
        PH_DATA
    } phase_e;

    phase_e    phase_q;
    isa_addr_t rd_ptr_q [`CCU_NUM_TGT];
    word_idx_t cnt_q;               // Matched words so far
    word_idx_t blk_len;
    opcode_e   tgt_op;
    logic      addr_hs;
    logic      dat_hs;
    logic      op_match;

    assign tgt_op = opcode_e'(`CCU_OPCODE_W'(grant_i));

    always_comb begin
        case (tgt_op)
            OP_SYA:  blk_len = word_idx_t'(`CCU_WORDS_SYA);
            OP_POL:  blk_len = word_idx_t'(`CCU_WORDS_POL);
            default: blk_len = word_idx_t'(`CCU_WORDS_CCU);
        endcase
    end

    assign addr_hs  = glb_addr_vld_o & glb_addr_rdy_i;
    assign dat_hs   = glb_dat_vld_i & glb_dat_rdy_o;
    assign op_match = (glb_dat_i[`CCU_OPCODE_W-1:0] == tgt_op);

    assign glb_addr_vld_o = (phase_q == PH_ADDR);
    assign glb_dat_rdy_o  = (phase_q == PH_DATA);   // One read outstanding
    assign glb_addr_o     = rd_ptr_q[grant_i];

    assign word_o      = glb_dat_i;
    assign word_stb_o  = dat_hs & op_match;
    assign word_idx_o  = cnt_q;
    assign word_last_o = (cnt_q == blk_len - word_idx_t'(1));

    //==========================================================================
    // Per-target read pointers
    //==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CCU_NUM_TGT; i++) begin
                rd_ptr_q[i] <= '0;
            end
        end else if (idle_i) begin
            for (int i = 0; i < `CCU_NUM_TGT; i++) begin
                rd_ptr_q[i] <= '0;
            end
        end else if (addr_hs) begin
            rd_ptr_q[grant_i] <= rd_ptr_q[grant_i] + isa_addr_t'(1);
        end
    end

    // Read phases, foreign words just trigger the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= PH_OFF;
            cnt_q   <= '0;
        end else begin
            case (phase_q)
                PH_OFF: begin
                    if (fetch_go_i) begin
                        phase_q <= PH_ADDR;
                        cnt_q   <= '0;
                    end
                end
                PH_ADDR: if (addr_hs) phase_q <= PH_DATA;
                PH_DATA: begin
                    if (dat_hs) begin
                        phase_q <= (op_match && word_last_o) ? PH_OFF : PH_ADDR;
                        if (op_match) begin
                            cnt_q <= cnt_q + word_idx_t'(1);
                        end
                    end
                end
                default: phase_q <= PH_OFF;
            endcase
        end
    end

endmodule

//--- design/isa_decoder.sv
`timescale 1ns/1ps
`include "ccu_consts.svh"

module isa_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ccu_cfg_pkg::tgt_e       grant_i,
    input  ccu_isa_pkg::isa_word_t  word_i,
    input  logic                    word_stb_i,
    input  ccu_isa_pkg::word_idx_t  word_idx_i,
    input  logic                    word_last_i,
    input  logic                    sya_rdy_i,
    input  logic                    pol_rdy_i,
    output ccu_isa_pkg::layer_cnt_t num_layers_o,
    output ccu_cfg_pkg::sya_cfg_t   sya_cfg_o,
    output ccu_cfg_pkg::pol_cfg_t   pol_cfg_o,
    output logic                    sya_cfg_vld_o,
    output logic                    pol_cfg_vld_o,
    output logic                    cfg_taken_o
);

    import ccu_isa_pkg::*;
    import ccu_cfg_pkg::*;

    // Fields packed upward from just above the opcode
    localparam int FLD_LSB     = `CCU_OPCODE_W;
    localparam int SYA_NIP_LSB = FLD_LSB + $bits(mode_t);
    localparam int SYA_CHI_LSB = SYA_NIP_LSB + $bits(idx_t);
    localparam int SYA_SCL_LSB = SYA_CHI_LSB + $bits(chn_t);
    localparam int SYA_SFT_LSB = SYA_SCL_LSB + $bits(qnt_scale_t);
    localparam int SYA_ZP_LSB  = SYA_SFT_LSB + $bits(act_t);
    localparam int SYA_WGT_LSB = FLD_LSB + $bits(isa_addr_t);
    localparam int SYA_OFM_LSB = SYA_WGT_LSB + $bits(isa_addr_t);
    localparam int POL_CHI_LSB = FLD_LSB + $bits(idx_t);
    localparam int POL_MAP_LSB = FLD_LSB + $bits(knn_k_t);

    sya_cfg_t   sya_q;
    pol_cfg_t   pol_q;
    layer_cnt_t layers_q;
    logic       sya_vld_q;
    logic       pol_vld_q;
    logic       ccu_taken_q;
    logic       blk_done;

    assign blk_done = word_stb_i & word_last_i;

    //==========================================================================
    // Field extraction
    //==========================================================================
    always_ff @(posedge clk) begin
        if (word_stb_i) begin
            case (grant_i)
                TGT_SYA: begin
                    if (word_idx_i == word_idx_t'(0)) begin
                        sya_q.mode  <= word_i[FLD_LSB     +: $bits(mode_t)];
                        sya_q.nip   <= word_i[SYA_NIP_LSB +: $bits(idx_t)];
                        sya_q.chi   <= word_i[SYA_CHI_LSB +: $bits(chn_t)];
                        sya_q.scale <= word_i[SYA_SCL_LSB +: $bits(qnt_scale_t)];
                        sya_q.shift <= word_i[SYA_SFT_LSB +: $bits(act_t)];
                        sya_q.zp    <= word_i[SYA_ZP_LSB  +: $bits(act_t)];
                    end else begin
                        sya_q.act_base <= word_i[FLD_LSB     +: $bits(isa_addr_t)];
                        sya_q.wgt_base <= word_i[SYA_WGT_LSB +: $bits(isa_addr_t)];
                        sya_q.ofm_base <= word_i[SYA_OFM_LSB +: $bits(isa_addr_t)];
                    end
                end
                TGT_POL: begin
                    if (word_idx_i == word_idx_t'(0)) begin
                        pol_q.nip <= word_i[FLD_LSB     +: $bits(idx_t)];
                        pol_q.chi <= word_i[POL_CHI_LSB +: $bits(chn_t)];
                    end else begin
                        pol_q.k        <= word_i[FLD_LSB     +: $bits(knn_k_t)];
                        pol_q.map_base <= word_i[POL_MAP_LSB +: $bits(isa_addr_t)];
                    end
                end
                default: ;   // CCU word handled below
            endcase
        end
    end

    // Layer count feeds the finish compare
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layers_q <= '0;
        end else if (word_stb_i && grant_i == TGT_CCU) begin
            layers_q <= word_i[FLD_LSB +: $bits(layer_cnt_t)];
        end
    end

    //==========================================================================
    // Delivery to targets
    //==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sya_vld_q   <= 1'b0;
            pol_vld_q   <= 1'b0;
            ccu_taken_q <= 1'b0;
        end else begin
            ccu_taken_q <= blk_done & (grant_i == TGT_CCU);   // Own ready is implied
            if (sya_vld_q && sya_rdy_i) begin
                sya_vld_q <= 1'b0;
            end else if (blk_done && grant_i == TGT_SYA) begin
                sya_vld_q <= 1'b1;
            end
            if (pol_vld_q && pol_rdy_i) begin
                pol_vld_q <= 1'b0;
            end else if (blk_done && grant_i == TGT_POL) begin
                pol_vld_q <= 1'b1;
            end
        end
    end

    assign cfg_taken_o   = ccu_taken_q | (sya_vld_q & sya_rdy_i) | (pol_vld_q & pol_rdy_i);
    assign num_layers_o  = layers_q;
    assign sya_cfg_o     = sya_q;
    assign pol_cfg_o     = pol_q;
    assign sya_cfg_vld_o = sya_vld_q;
    assign pol_cfg_vld_o = pol_vld_q;

endmodule

//--- design/ccu_top.sv
`timescale 1ns/1ps

module ccu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    output ccu_isa_pkg::isa_addr_t glb_addr_o,
    output logic                   glb_addr_vld_o,
    input  logic                   glb_addr_rdy_i,
    input  ccu_isa_pkg::isa_word_t glb_dat_i,
    input  logic                   glb_dat_vld_i,
    output logic                   glb_dat_rdy_o,
    output ccu_cfg_pkg::sya_cfg_t  sya_cfg_o,
    output logic                   sya_cfg_vld_o,
    input  logic                   sya_rdy_i,
    output logic                   sya_rst_o,
    output ccu_cfg_pkg::pol_cfg_t  pol_cfg_o,
    output logic                   pol_cfg_vld_o,
    input  logic                   pol_rdy_i,
    output logic                   pol_rst_o,
    output logic                   net_done_o
);

    import ccu_isa_pkg::*;
    import ccu_cfg_pkg::*;

    logic       fetch_go;
    tgt_e       grant;
    logic       idle;
    logic       cfg_taken;
    layer_cnt_t num_layers;
    isa_word_t  word;
    logic       word_stb;
    word_idx_t  word_idx;
    logic       word_last;

    ccu_sequencer u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .sya_rdy_i    (sya_rdy_i),
        .pol_rdy_i    (pol_rdy_i),
        .cfg_taken_i  (cfg_taken),
        .num_layers_i (num_layers),
        .fetch_go_o   (fetch_go),
        .grant_o      (grant),
        .net_done_o   (net_done_o),
        .sya_rst_o    (sya_rst_o),
        .pol_rst_o    (pol_rst_o),
        .idle_o       (idle)
    );

    isa_fetch u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .idle_i         (idle),
        .fetch_go_i     (fetch_go),
        .grant_i        (grant),
        .glb_addr_o     (glb_addr_o),
        .glb_addr_vld_o (glb_addr_vld_o),
        .glb_addr_rdy_i (glb_addr_rdy_i),
        .glb_dat_i      (glb_dat_i),
        .glb_dat_vld_i  (glb_dat_vld_i),
        .glb_dat_rdy_o  (glb_dat_rdy_o),
        .word_o         (word),
        .word_stb_o     (word_stb),
        .word_idx_o     (word_idx),
        .word_last_o    (word_last)
    );

    isa_decoder u_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .grant_i       (grant),
        .word_i        (word),
        .word_stb_i    (word_stb),
        .word_idx_i    (word_idx),
        .word_last_i   (word_last),
        .sya_rdy_i     (sya_rdy_i),
        .pol_rdy_i     (pol_rdy_i),
        .num_layers_o  (num_layers),
        .sya_cfg_o     (sya_cfg_o),
        .pol_cfg_o     (pol_cfg_o),
        .sya_cfg_vld_o (sya_cfg_vld_o),
        .pol_cfg_vld_o (pol_cfg_vld_o),
        .cfg_taken_o   (cfg_taken)
    );

endmodule

//--- dv/glb_isa_model.sv
`timescale 1ns/1ps
`include "ccu_consts.svh"

module glb_isa_model (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall_en_i,
    input  ccu_isa_pkg::isa_addr_t addr_i,
    input  logic                   addr_vld_i,
    output logic                   addr_rdy_o,
    output ccu_isa_pkg::isa_word_t dat_o,
    output logic                   dat_vld_o,
    input  logic                   dat_rdy_i
);

    import ccu_isa_pkg::*;

    isa_word_t   mem [0:63];       // Loaded by the test tasks
    logic        pend;
    isa_addr_t   addr_q;
    logic [31:0] rnd_q = 32'd52351;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Handshakes are seen on the rising edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend   <= 1'b0;
            addr_q <= '0;
        end else begin
            if (addr_vld_i && addr_rdy_o) begin
                pend   <= 1'b1;
                addr_q <= addr_i;
            end
            if (dat_vld_o && dat_rdy_i) begin
                pend <= 1'b0;
            end
        end
    end

    // Outputs change on the falling edge, stalled about one cycle in four
    initial begin
        addr_rdy_o = 1'b0;
        dat_vld_o  = 1'b0;
        dat_o      = '0;
        forever begin
            @(negedge clk);
            rnd_q      = xorshift(rnd_q);
            addr_rdy_o = !pend && (!stall_en_i || rnd_q[1:0] != 2'd0);
            dat_vld_o  = pend && (dat_vld_o || !stall_en_i || rnd_q[3:2] != 2'd0);
            dat_o      = mem[addr_q[5:0]];
        end
    end

endmodule

//--- dv/ccu_tb.sv
`timescale 1ns/1ps
`include "ccu_consts.svh"

module ccu_tb;

    import ccu_isa_pkg::*;
    import ccu_cfg_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_TESTS   = 5;
    localparam int MAX_WORDS   = 24;      // Reads per test, worst case
    localparam int MAX_STALL   = 32;      // Cycles per read, worst case
    localparam int WATCHDOG_NS = NUM_TESTS * MAX_WORDS * MAX_STALL * CLK_PERIOD + 20000;
    localparam int WAIT_CYCLES = MAX_WORDS * MAX_STALL;

    logic clk;
    logic rst_n;
    logic start_i;
    logic sya_rdy;
    logic pol_rdy;
    logic stall_en;
    isa_addr_t glb_addr;
    logic glb_addr_vld;
    logic glb_addr_rdy;
    isa_word_t glb_dat;
    logic glb_dat_vld;
    logic glb_dat_rdy;
    sya_cfg_t sya_cfg_o;
    logic sya_cfg_vld_o;
    logic sya_rst_o;
    pol_cfg_t pol_cfg_o;
    logic pol_cfg_vld_o;
    logic pol_rst_o;
    logic net_done_o;

    sya_cfg_t sya_got[$];
    pol_cfg_t pol_got[$];
    int order[$];                          // 1 for SYA, 2 for POL
    int done_cnt;
    int done_at_sya;
    int addr_hs_cnt;
    int errors;
    int failed_tests;
    logic [31:0] rnd = 32'd52351;

    ccu_top ccu_top_i (
        .clk(clk), .rst_n(rst_n), .start_i(start_i),
        .glb_addr_o(glb_addr), .glb_addr_vld_o(glb_addr_vld), .glb_addr_rdy_i(glb_addr_rdy),
        .glb_dat_i(glb_dat), .glb_dat_vld_i(glb_dat_vld), .glb_dat_rdy_o(glb_dat_rdy),
        .sya_cfg_o(sya_cfg_o), .sya_cfg_vld_o(sya_cfg_vld_o), .sya_rdy_i(sya_rdy),
        .sya_rst_o(sya_rst_o), .pol_cfg_o(pol_cfg_o), .pol_cfg_vld_o(pol_cfg_vld_o),
        .pol_rdy_i(pol_rdy), .pol_rst_o(pol_rst_o), .net_done_o(net_done_o)
    );

    glb_isa_model u_glb (
        .clk(clk), .rst_n(rst_n), .stall_en_i(stall_en),
        .addr_i(glb_addr), .addr_vld_i(glb_addr_vld), .addr_rdy_o(glb_addr_rdy),
        .dat_o(glb_dat), .dat_vld_o(glb_dat_vld), .dat_rdy_i(glb_dat_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // Deliveries, done pulses and address handshakes
    always @(posedge clk) begin
        if (sya_cfg_vld_o && sya_rdy) begin
            sya_got.push_back(sya_cfg_o);
            order.push_back(1);
        end
        if (pol_cfg_vld_o && pol_rdy) begin
            pol_got.push_back(pol_cfg_o);
            order.push_back(2);
        end
        if (net_done_o) begin
            done_cnt++;
            done_at_sya = sya_got.size();
        end
        if (glb_addr_vld && glb_addr_rdy) addr_hs_cnt++;
    end

    //==========================================================================
    // Helpers
    //==========================================================================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic sya_cfg_t rand_sya();
        sya_cfg_t c;
        rnd = xorshift(rnd);
        c[63:32] = rnd;
        rnd = xorshift(rnd);
        c[31:0] = rnd;
        rnd = xorshift(rnd);
        c[95:64] = rnd;
        rnd = xorshift(rnd);
        c[113:96] = rnd[17:0];
        return c;
    endfunction

    function automatic pol_cfg_t rand_pol();
        pol_cfg_t c;
        rnd = xorshift(rnd);
        c[31:0] = rnd;
        rnd = xorshift(rnd);
        c[49:32] = rnd[17:0];
        return c;
    endfunction

    task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // Foreign opcode 0xff with the address above it
    task automatic clear_isa();
        for (int a = 0; a < 64; a++) begin
            u_glb.mem[a] = isa_word_t'({16'(a), 8'(a ^ 8'h5a), 8'hff});
        end
    endtask

    task automatic put_ccu(input int a, input layer_cnt_t layers);
        u_glb.mem[a] = isa_word_t'({layers, 8'd0});
    endtask

    task automatic put_sya(input int a0, input int a1, input sya_cfg_t c);
        u_glb.mem[a0] = isa_word_t'({c.zp, c.shift, c.scale, c.chi, c.nip, c.mode, 8'd1});
        u_glb.mem[a1] = isa_word_t'({c.ofm_base, c.wgt_base, c.act_base, 8'd1});
    endtask

    task automatic put_pol(input int a0, input int a1, input pol_cfg_t c);
        u_glb.mem[a0] = isa_word_t'({c.chi, c.nip, 8'd2});
        u_glb.mem[a1] = isa_word_t'({c.map_base, c.k, 8'd2});
    endtask

    task automatic start_net();
        sya_got.delete();
        pol_got.delete();
        order.delete();
        done_cnt    = 0;
        done_at_sya = 0;
        addr_hs_cnt = 0;
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        if (sya_rst_o || pol_rst_o) begin
            $display("Target resets still high after start");
            errors++;
        end
    endtask

    task automatic wait_cond_sya(input int n);
        int t;
        t = 0;
        while (sya_got.size() < n && t < WAIT_CYCLES) begin
            @(negedge clk);
            t++;
        end
        if (sya_got.size() < n) begin
            $display("Timed out waiting for SYA delivery %0d", n);
            errors++;
        end
    endtask

    task automatic wait_done();
        int t;
        t = 0;
        while (!net_done_o && t < WAIT_CYCLES) begin
            @(negedge clk);
            t++;
        end
        if (!net_done_o) begin
            $display("Timed out waiting for net_done_o");
            errors++;
        end
        @(negedge clk);
        @(negedge clk);
        check_val("sya_rst_o", sya_rst_o, 1'b1);
        check_val("pol_rst_o", pol_rst_o, 1'b1);
        check_val("done_cnt", done_cnt, 1);
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed", name);
            failed_tests++;
        end
    endtask

    //==========================================================================
    // Directed tests
    //==========================================================================
    task automatic test_reset();
        int e;
        e = errors;
        check_val("sya_cfg_vld_o", sya_cfg_vld_o, 1'b0);
        check_val("pol_cfg_vld_o", pol_cfg_vld_o, 1'b0);
        check_val("glb_addr_vld_o", glb_addr_vld, 1'b0);
        check_val("glb_dat_rdy_o", glb_dat_rdy, 1'b0);
        check_val("net_done_o", net_done_o, 1'b0);
        check_val("sya_rst_o", sya_rst_o, 1'b1);
        check_val("pol_rst_o", pol_rst_o, 1'b1);
        finish_test("reset state", e);
    endtask

    task automatic test_single_layer();
        int e;
        sya_cfg_t s;
        e = errors;
        s = rand_sya();
        clear_isa();
        put_ccu(0, 20'd1);
        put_sya(1, 2, s);
        sya_rdy = 1'b1;
        start_net();
        wait_done();
        sya_rdy = 1'b0;
        check_val("sya deliveries", sya_got.size(), 1);
        check_val("done_at_sya", done_at_sya, 1);
        if (sya_got.size() > 0) check_val("sya_cfg_o", sya_got[0], s);
        finish_test("single layer", e);
    endtask

    task automatic test_foreign_skip();
        int e;
        sya_cfg_t s0;
        sya_cfg_t s1;
        pol_cfg_t p;
        e = errors;
        s0 = rand_sya();
        s1 = rand_sya();
        p  = rand_pol();
        clear_isa();
        put_ccu(0, 20'd2);
        put_pol(1, 3, p);
        put_sya(2, 4, s0);
        put_sya(5, 6, s1);
        sya_rdy = 1'b1;
        pol_rdy = 1'b1;
        start_net();
        wait_cond_sya(1);
        sya_rdy = 1'b0;          // Let POL win the next arbitration
        while (pol_got.size() == 0 && !net_done_o && errors == e) @(negedge clk);
        pol_rdy = 1'b0;
        sya_rdy = 1'b1;
        wait_done();
        sya_rdy = 1'b0;
        check_val("sya deliveries", sya_got.size(), 2);
        check_val("pol deliveries", pol_got.size(), 1);
        if (order.size() > 0) check_val("first delivery", order[0], 1);
        if (sya_got.size() > 1) check_val("sya_cfg_o", sya_got[0], s0);
        if (sya_got.size() > 1) check_val("sya_cfg_o", sya_got[1], s1);
        if (pol_got.size() > 0) check_val("pol_cfg_o", pol_got[0], p);
        finish_test("foreign opcodes skipped", e);
    endtask

    task automatic test_two_layers();
        int e;
        sya_cfg_t s0;
        sya_cfg_t s1;
        e = errors;
        s0 = rand_sya();
        s1 = rand_sya();
        clear_isa();
        put_ccu(0, 20'd2);
        put_sya(1, 2, s0);
        put_sya(3, 4, s1);
        sya_rdy = 1'b1;
        start_net();
        wait_cond_sya(1);
        sya_rdy = 1'b0;
        repeat (5) @(negedge clk);
        check_val("done_cnt", done_cnt, 0);
        sya_rdy = 1'b1;
        wait_done();
        sya_rdy = 1'b0;
        check_val("done_at_sya", done_at_sya, 2);
        if (sya_got.size() > 1) check_val("sya_cfg_o", sya_got[0], s0);
        if (sya_got.size() > 1) check_val("sya_cfg_o", sya_got[1], s1);
        finish_test("two layers", e);
    endtask

    task automatic test_back_pressure();
        int e;
        sya_cfg_t exp_q[2];
        sya_cfg_t snap;
        e = errors;
        exp_q[0] = rand_sya();
        exp_q[1] = rand_sya();
        clear_isa();
        put_sya(0, 3, exp_q[0]);
        put_ccu(1, 20'd2);
        put_sya(4, 6, exp_q[1]);
        sya_rdy = 1'b1;
        start_net();
        while (addr_hs_cnt < 3 && errors == e && !net_done_o) @(negedge clk);
        sya_rdy = 1'b0;          // SYA already granted, hold the valid back
        for (int b = 0; b < 2; b++) begin
            for (int t = 0; t < WAIT_CYCLES && !sya_cfg_vld_o; t++) @(negedge clk);
            snap = sya_cfg_o;
            repeat (6) begin
                @(negedge clk);
                check_val("sya_cfg_vld_o", sya_cfg_vld_o, 1'b1);
                check_val("sya_cfg_o held", sya_cfg_o, snap);
            end
            sya_rdy = 1'b1;
            wait_cond_sya(b + 1);
            if (b == 0) begin
                @(negedge clk);
                sya_rdy = 1'b0;
            end
        end
        wait_done();
        sya_rdy = 1'b0;
        check_val("sya deliveries", sya_got.size(), 2);
        for (int b = 0; b < 2 && b < sya_got.size(); b++) begin
            check_val("sya_cfg_o", sya_got[b], exp_q[b]);
        end
        finish_test("back-pressure", e);
    endtask

    initial begin
        rst_n        = 1'b0;
        start_i      = 1'b0;
        sya_rdy      = 1'b0;
        pol_rdy      = 1'b0;
        stall_en     = 1'b0;
        errors       = 0;
        failed_tests = 0;
        clear_isa();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_single_layer();
        stall_en = 1'b1;
        test_foreign_skip();
        test_two_layers();
        test_back_pressure();
        $display("Tests run %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- ccu_top.f
+incdir+design
design/ccu_isa_pkg.sv
design/ccu_cfg_pkg.sv
design/ccu_sequencer.sv
design/isa_fetch.sv
design/isa_decoder.sv
design/ccu_top.sv
dv/glb_isa_model.sv
dv/ccu_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = ccu_tb
FILELIST  = ccu_top.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
